/* hw/sort_pkg.sv */
package sort_pkg;

  // Datapath word
  localparam int W = 32;
  typedef logic [W-1:0] W_T;

  // Microcode program counter
  localparam int PC_W = 6;
  typedef logic [PC_W-1:0] PC_T;

  // Architectural registers, r0 reads as zero
  localparam int REG_N = 8;
  typedef logic [$clog2(REG_N)-1:0] REG_T;

  // Link register written by CALL
  localparam REG_T BLINK = REG_T'(7);

  // Hardware stack depth, head included
  localparam int STACK_N = 32;

  // Largest bank and its word address
  localparam int BANK_N = 16;
  typedef logic [$clog2(BANK_N)-1:0] ADDR_T;

  typedef enum logic [1:0] {
    IDLE    = 2'd0,
    READY   = 2'd1,
    SORTING = 2'd2,
    SORTED  = 2'd3
  } BANK_STATUS_T;

  typedef struct packed {
    BANK_STATUS_T            status;
    // Word count, 0 up to BANK_N inclusive
    logic [$clog2(BANK_N):0] n;
  } BANK_STATE_T;

  // Condition codes tested against the committed flags
  typedef enum logic [1:0] {
    ALWAYS = 2'd0,
    EQ     = 2'd1,
    GT     = 2'd2,
    LE     = 2'd3
  } CC_T;

  typedef enum logic [3:0] {
    ALU   = 4'd0,
    JUMP  = 4'd1,
    CALL  = 4'd2,
    RET   = 4'd3,
    PUSH  = 4'd4,
    POP   = 4'd5,
    LOAD  = 4'd6,
    STORE = 4'd7,
    AWAIT = 4'd8,
    DONE  = 4'd9
  } OPCODE_T;

  // ROM word, 24 bits
  typedef struct packed {
    OPCODE_T         opcode;
    CC_T             cc;
    REG_T            dst;
    REG_T            src0;
    REG_T            src1;
    // Doubles as jump or call target
    logic [PC_W-1:0] imm;
    logic            has_imm;
    // Operand B taken from N
    logic            special;
    logic            inv_src1;
  } INST_T;

  // Decoded control word
  typedef struct packed {
    REG_T            dst;
    logic            dst_en;
    REG_T            src0;
    REG_T            src1;
    logic            src0_is_zero;
    logic            has_imm;
    logic [PC_W-1:0] imm;
    logic            has_special;
    logic            inv_src1;
    logic            cin;
    logic            flag_en;
    logic            is_jump;
    logic            is_call;
    logic            is_ret;
    logic            dst_is_blink;
    logic            is_push;
    logic            is_pop;
    logic            is_load;
    logic            is_store;
    logic            is_await;
    logic            is_done;
    CC_T             cc;
    PC_T             target;
  } UCODE_T;

  typedef struct packed {
    logic c;
    logic n;
    logic z;
  } FLAGS_T;

  // Push when set, pop otherwise
  typedef struct packed {
    logic push;
    W_T   push_dat;
  } STACK_CMD_T;

  typedef struct packed {
    logic  en;
    logic  wen;
    ADDR_T addr;
    W_T    wdata;
  } BANK_REQ_T;

  function automatic PC_T pc_inc(PC_T pc);
    return pc + PC_T'(1);
  endfunction

endpackage

/* hw/ucode_rom.sv */
`timescale 1ns/10ps

module ucode_rom import sort_pkg::*; (
  input  PC_T   pc,
  output INST_T inst
);

  // Bank reversal program
  // r1 holds N, r2 the word index, r3 the data word, r7 the link
  // Field order: opcode cc dst src0 src1 imm has_imm special inv_src1
  always_comb begin
    case (pc)
      // Park until the scoreboard hands over a bank
      6'd0:  inst = {AWAIT, ALWAYS, 3'd0, 3'd0, 3'd0, 6'd0,  1'b0, 1'b0, 1'b0};
      // r1 = N
      6'd1:  inst = {ALU,   ALWAYS, 3'd1, 3'd0, 3'd0, 6'd0,  1'b0, 1'b1, 1'b0};
      // r2 = 0
      6'd2:  inst = {ALU,   ALWAYS, 3'd2, 3'd0, 3'd0, 6'd0,  1'b1, 1'b0, 1'b0};
      // Push loop, r3 = bank[r2]
      6'd3:  inst = {LOAD,  ALWAYS, 3'd3, 3'd2, 3'd0, 6'd0,  1'b0, 1'b0, 1'b0};
      // Forwarded from the load
      6'd4:  inst = {PUSH,  ALWAYS, 3'd0, 3'd0, 3'd3, 6'd0,  1'b0, 1'b0, 1'b0};
      6'd5:  inst = {ALU,   ALWAYS, 3'd2, 3'd2, 3'd0, 6'd1,  1'b1, 1'b0, 1'b0};
      // Flags from r1 - r2, result dropped into r0
      6'd6:  inst = {ALU,   ALWAYS, 3'd0, 3'd1, 3'd2, 6'd0,  1'b0, 1'b0, 1'b1};
      6'd7:  inst = {JUMP,  GT,     3'd0, 3'd0, 3'd0, 6'd3,  1'b0, 1'b0, 1'b0};
      // Restart index for the pop loop
      6'd8:  inst = {ALU,   ALWAYS, 3'd2, 3'd0, 3'd0, 6'd0,  1'b1, 1'b0, 1'b0};
      // Pop loop, r3 = top of stack
      6'd9:  inst = {POP,   ALWAYS, 3'd3, 3'd0, 3'd0, 6'd0,  1'b0, 1'b0, 1'b0};
      // Call the store routine at 16
      6'd10: inst = {CALL,  ALWAYS, 3'd0, 3'd0, 3'd0, 6'd16, 1'b1, 1'b0, 1'b0};
      6'd11: inst = {ALU,   ALWAYS, 3'd2, 3'd2, 3'd0, 6'd1,  1'b1, 1'b0, 1'b0};
      6'd12: inst = {ALU,   ALWAYS, 3'd0, 3'd1, 3'd2, 6'd0,  1'b0, 1'b0, 1'b1};
      6'd13: inst = {JUMP,  GT,     3'd0, 3'd0, 3'd0, 6'd9,  1'b0, 1'b0, 1'b0};
      // Bank reversed
      6'd14: inst = {DONE,  ALWAYS, 3'd0, 3'd0, 3'd0, 6'd0,  1'b0, 1'b0, 1'b0};
      6'd15: inst = {JUMP,  ALWAYS, 3'd0, 3'd0, 3'd0, 6'd0,  1'b0, 1'b0, 1'b0};
      // Store routine, bank[r2] = r3
      6'd16: inst = {STORE, ALWAYS, 3'd0, 3'd2, 3'd3, 6'd0,  1'b0, 1'b0, 1'b0};
      // Return through r7
      6'd17: inst = {RET,   ALWAYS, 3'd0, 3'd0, 3'd7, 6'd0,  1'b0, 1'b0, 1'b0};
      // Unused space falls back to the top
      default: begin
        inst = {JUMP, ALWAYS, 3'd0, 3'd0, 3'd0, 6'd0, 1'b0, 1'b0, 1'b0};
      end
    endcase
  end

endmodule

/* hw/ucode_decoder.sv */
`timescale 1ns/10ps

module ucode_decoder import sort_pkg::*; (
  input  INST_T  inst,
  output UCODE_T ucode
);

  // Opcode produces a register result
  logic dst_wr;

  always_comb begin
    ucode  = '0;
    dst_wr = 1'b0;

    // Operand fields straight from the word
    ucode.dst          = inst.dst;
    ucode.src0         = inst.src0;
    ucode.src1         = inst.src1;
    ucode.src0_is_zero = (inst.src0 == '0);
    ucode.has_imm      = inst.has_imm;
    ucode.imm          = inst.imm;
    // Special operand is the bank word count
    ucode.has_special  = inst.special;
    ucode.inv_src1     = inst.inv_src1;
    // Subtract as A + ~B + 1
    ucode.cin          = inst.inv_src1;
    ucode.cc           = inst.cc;
    ucode.target       = inst.imm;

    case (inst.opcode)
      ALU: begin
        dst_wr        = 1'b1;
        ucode.flag_en = 1'b1;
      end
      JUMP:  ucode.is_jump = 1'b1;
      CALL: begin
        // Return address always lands in the link register
        dst_wr             = 1'b1;
        ucode.is_call      = 1'b1;
        ucode.dst          = BLINK;
        ucode.dst_is_blink = 1'b1;
      end
      RET:   ucode.is_ret = 1'b1;
      PUSH:  ucode.is_push = 1'b1;
      POP: begin
        dst_wr       = 1'b1;
        ucode.is_pop = 1'b1;
      end
      LOAD: begin
        dst_wr        = 1'b1;
        ucode.is_load = 1'b1;
      end
      STORE: ucode.is_store = 1'b1;
      AWAIT: ucode.is_await = 1'b1;
      DONE:  ucode.is_done = 1'b1;
      // Unknown opcodes retire as no-ops
      default: dst_wr = 1'b0;
    endcase

    // r0 never written, so never forwarded either
    ucode.dst_en = dst_wr & (ucode.dst != '0);
  end

endmodule

/* hw/reg_file.sv */
`timescale 1ns/10ps

module reg_file import sort_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  REG_T [1:0] ra,
  output W_T [1:0]   rdata,
  input  logic       wen,
  input  REG_T       wa,
  input  W_T         wdata
);

  W_T regs [REG_N];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < REG_N; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && (wa != '0)) begin
      regs[wa] <= wdata;
    end
  end

  // Two asynchronous read ports
  // r0 pinned to zero
  always_comb begin
    for (int p = 0; p < 2; p++) begin
      rdata[p] = (ra[p] == '0) ? '0 : regs[ra[p]];
    end
  end

endmodule

/* hw/hw_stack.sv */
`timescale 1ns/10ps

module hw_stack import sort_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       cmd_vld,
  input  STACK_CMD_T cmd,
  output W_T         head,
  output logic       empty,
  output logic       full
);

  // Entries below the head
  W_T                         mem [STACK_N];
  // Occupancy, head included
  logic [$clog2(STACK_N):0]   cnt;
  // Slot that takes the old head on push
  logic [$clog2(STACK_N)-1:0] wr_idx;
  // Slot that becomes the head on pop
  logic [$clog2(STACK_N)-1:0] rd_idx;

  assign empty  = (cnt == '0);
  assign full   = (int'(cnt) == STACK_N);
  assign wr_idx = cnt[$clog2(STACK_N)-1:0] - 1'b1;
  assign rd_idx = wr_idx - 1'b1;

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt <= '0;
    end else if (cmd_vld) begin
      cnt <= cmd.push ? cnt + 1'b1 : cnt - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_vld) begin
      if (cmd.push) begin
        head <= cmd.push_dat;
        // Old head spills into the array
        if (!empty) begin
          mem[wr_idx] <= head;
        end
      end else begin
        head <= mem[rd_idx];
      end
    end
  end

  // Program depth must stay within the stack
  assert property (@(posedge clk) disable iff (rst) (cmd_vld && cmd.push) |-> !full);
  assert property (@(posedge clk) disable iff (rst) (cmd_vld && !cmd.push) |-> !empty);

endmodule

/* hw/fetch_stage.sv */
`timescale 1ns/10ps

module fetch_stage import sort_pkg::*; (
  input  logic clk,
  input  logic rst,
  input  logic xa_stall,
  input  logic replay,
  input  PC_T  replay_pc,
  output logic fa_vld,
  output PC_T  fa_pc,
  output logic fa_adv
);

  // Hands the fetched word to XA unless flushed or XA held
  assign fa_adv = fa_vld & ~replay & ~xa_stall;

  always_ff @(posedge clk) begin
    if (rst) begin
      fa_vld <= 1'b0;
      fa_pc  <= '0;
    end else begin
      // Valid from the first cycle out of reset
      fa_vld <= 1'b1;
      if (replay) begin
        // Redirect from commit
        fa_pc <= replay_pc;
      end else if (fa_adv) begin
        fa_pc <= pc_inc(fa_pc);
      end
    end
  end

  // XA is flushed behind a redirect, so replay lasts a single cycle
  assert property (@(posedge clk) disable iff (rst) replay |=> !replay);

endmodule

/* hw/exec_stage.sv */
`timescale 1ns/10ps

module exec_stage import sort_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        fa_vld,
  input  logic        fa_adv,
  input  PC_T         fa_pc,
  input  INST_T       inst,
  output logic        xa_stall,
  output logic        replay,
  output PC_T         replay_pc,
  output REG_T [1:0]  rf_ra,
  input  W_T [1:0]    rf_rdata,
  output logic        rf_wen,
  output REG_T        rf_wa,
  output W_T          rf_wdata,
  output logic        stack_cmd_vld,
  output STACK_CMD_T  stack_cmd,
  input  W_T          stack_head,
  input  BANK_STATE_T bank_in,
  input  W_T          bank_rdata,
  output BANK_REQ_T   bank_req,
  output logic        bank_out_vld,
  output BANK_STATE_T bank_out
);

  // XA stage state
  logic   xa_vld;
  PC_T    xa_pc;
  INST_T  xa_inst;
  UCODE_T xa_ucode;
  logic   xa_commit;
  // Datapath
  logic   cc_hit;
  logic   src0_fwd;
  logic   src1_fwd;
  W_T     alu_a;
  W_T     alu_b_pre;
  W_T     alu_b;
  W_T     alu_y;
  logic   alu_cout;
  FLAGS_T ar_flags;
  W_T     wb_data;
  logic   redirect;
  PC_T    redirect_pc;

  ucode_decoder u_ucode_decoder (
    .inst  (xa_inst),
    .ucode (xa_ucode)
  );

  // AWAIT holds XA until a READY bank shows up
  assign xa_stall  = xa_vld & xa_ucode.is_await & (bank_in.status != READY);
  // Replay flushes whatever sits in XA
  assign xa_commit = xa_vld & ~xa_stall & ~replay;

  assign rf_ra[0] = xa_ucode.src0;
  assign rf_ra[1] = xa_ucode.src1;
  // CA result still on its way into the register file
  assign src0_fwd = rf_wen & (rf_wa == xa_ucode.src0);
  assign src1_fwd = rf_wen & (rf_wa == xa_ucode.src1);

  always_comb begin
    // Condition against committed flags
    case (xa_ucode.cc)
      EQ:      cc_hit = ar_flags.z;
      GT:      cc_hit = ~ar_flags.z & ~ar_flags.n;
      LE:      cc_hit = ar_flags.z | ar_flags.n;
      default: cc_hit = 1'b1;
    endcase

    // Operand A
    if (xa_ucode.src0_is_zero) begin
      alu_a = '0;
    end else if (src0_fwd) begin
      alu_a = rf_wdata;
    end else begin
      alu_a = rf_rdata[0];
    end

    // Operand B, N first, then immediate, then registers
    if (xa_ucode.has_special) begin
      alu_b_pre = W_T'(bank_in.n);
    end else if (xa_ucode.has_imm) begin
      alu_b_pre = W_T'(xa_ucode.imm);
    end else if (src1_fwd) begin
      alu_b_pre = rf_wdata;
    end else begin
      alu_b_pre = rf_rdata[1];
    end
    alu_b = alu_b_pre ^ {W{xa_ucode.inv_src1}};

    {alu_cout, alu_y} = {1'b0, alu_a} + {1'b0, alu_b} + {{W{1'b0}}, xa_ucode.cin};

    // Writeback source
    if (xa_ucode.is_pop) begin
      wb_data = stack_head;
    end else if (xa_ucode.dst_is_blink) begin
      // Link is the word after the CALL
      wb_data = W_T'(pc_inc(xa_pc));
    end else if (xa_ucode.is_load) begin
      wb_data = bank_rdata;
    end else begin
      wb_data = alu_y;
    end

    // Taken jump, CALL or RET restarts fetch
    redirect    = xa_commit & ((xa_ucode.is_jump & cc_hit) | xa_ucode.is_ret
                               | xa_ucode.is_call);
    redirect_pc = xa_ucode.is_jump ? xa_ucode.target : PC_T'(alu_b);

    // Bank port, address from A, store data from B
    bank_req.en    = xa_commit & (xa_ucode.is_load | xa_ucode.is_store);
    bank_req.wen   = xa_commit & xa_ucode.is_store;
    bank_req.addr  = ADDR_T'(alu_a);
    bank_req.wdata = alu_b;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      xa_vld        <= 1'b0;
      replay        <= 1'b0;
      rf_wen        <= 1'b0;
      stack_cmd_vld <= 1'b0;
      bank_out_vld  <= 1'b0;
      ar_flags      <= '0;
    end else begin
      if (replay) begin
        xa_vld <= 1'b0;
      end else if (!xa_stall) begin
        xa_vld <= fa_vld;
      end
      replay        <= redirect;
      rf_wen        <= xa_commit & xa_ucode.dst_en;
      stack_cmd_vld <= xa_commit & (xa_ucode.is_push | xa_ucode.is_pop);
      // Status update for AWAIT and DONE
      bank_out_vld  <= xa_commit & (xa_ucode.is_await | xa_ucode.is_done);
      if (xa_commit && xa_ucode.flag_en) begin
        ar_flags.c <= alu_cout;
        ar_flags.n <= alu_y[W-1];
        ar_flags.z <= (alu_y == '0);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fa_adv) begin
      xa_inst <= inst;
      xa_pc   <= fa_pc;
    end
    replay_pc          <= redirect_pc;
    rf_wa              <= xa_ucode.dst;
    rf_wdata           <= wb_data;
    stack_cmd.push     <= xa_ucode.is_push;
    stack_cmd.push_dat <= alu_b;
    bank_out.status    <= xa_ucode.is_await ? SORTING : SORTED;
    bank_out.n         <= bank_in.n;
  end

  // AWAIT and DONE never commit back to back
  assert property (@(posedge clk) disable iff (rst) bank_out_vld |=> !bank_out_vld);

endmodule

/* hw/sort_engine.sv */
`timescale 1ns/10ps

module sort_engine import sort_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  BANK_STATE_T bank_in,
  output logic        bank_out_vld,
  output BANK_STATE_T bank_out,
  output BANK_REQ_T   bank_req,
  input  W_T          bank_rdata
);

  // FA
  logic       fa_vld;
  PC_T        fa_pc;
  logic       fa_adv;
  INST_T      fa_inst;
  // XA to FA
  logic       xa_stall;
  logic       replay;
  PC_T        replay_pc;
  // Register file
  REG_T [1:0] rf_ra;
  W_T [1:0]   rf_rdata;
  logic       rf_wen;
  REG_T       rf_wa;
  W_T         rf_wdata;
  // Stack
  logic       stack_cmd_vld;
  STACK_CMD_T stack_cmd;
  W_T         stack_head;

  fetch_stage u_fetch_stage (
    .clk       (clk),
    .rst       (rst),
    .xa_stall  (xa_stall),
    .replay    (replay),
    .replay_pc (replay_pc),
    .fa_vld    (fa_vld),
    .fa_pc     (fa_pc),
    .fa_adv    (fa_adv)
  );

  ucode_rom u_ucode_rom (
    .pc   (fa_pc),
    .inst (fa_inst)
  );

  exec_stage u_exec_stage (
    .clk           (clk),
    .rst           (rst),
    .fa_vld        (fa_vld),
    .fa_adv        (fa_adv),
    .fa_pc         (fa_pc),
    .inst          (fa_inst),
    .xa_stall      (xa_stall),
    .replay        (replay),
    .replay_pc     (replay_pc),
    .rf_ra         (rf_ra),
    .rf_rdata      (rf_rdata),
    .rf_wen        (rf_wen),
    .rf_wa         (rf_wa),
    .rf_wdata      (rf_wdata),
    .stack_cmd_vld (stack_cmd_vld),
    .stack_cmd     (stack_cmd),
    .stack_head    (stack_head),
    .bank_in       (bank_in),
    .bank_rdata    (bank_rdata),
    .bank_req      (bank_req),
    .bank_out_vld  (bank_out_vld),
    .bank_out      (bank_out)
  );

  reg_file u_reg_file (
    .clk   (clk),
    .rst   (rst),
    .ra    (rf_ra),
    .rdata (rf_rdata),
    .wen   (rf_wen),
    .wa    (rf_wa),
    .wdata (rf_wdata)
  );

  // Status flags only feed the stack's own checks
  hw_stack u_hw_stack (
    .clk     (clk),
    .rst     (rst),
    .cmd_vld (stack_cmd_vld),
    .cmd     (stack_cmd),
    .head    (stack_head),
    .empty   (),
    .full    ()
  );

endmodule

/* tests/tb_sort_engine.sv */
`timescale 1ns/10ps

module tb_sort_engine import sort_pkg::*; ();

  localparam int CLK_NS          = 10;
  localparam int RESET_CYCLES    = 8;
  localparam int BANKS           = 4;
  localparam int CYCLES_PER_BANK = 2000;
  // Extra room for reset and the idle phase
  localparam int WATCHDOG_NS     = (BANKS * CYCLES_PER_BANK + 100) * CLK_NS;

  logic        clk = 1'b0;
  logic        rst;
  BANK_STATE_T bank_in;
  logic        bank_out_vld;
  BANK_STATE_T bank_out;
  BANK_REQ_T   bank_req;
  W_T          bank_rdata;

  // Bank memory and the words it held before the engine ran
  W_T                mem [BANK_N];
  W_T                ref_mem [BANK_N];
  // Copies ref_mem into the bank and clears the write tally
  logic              fill;
  int                cur_n;
  int                wr_cnt;
  logic [BANK_N-1:0] wr_seen;
  int                seed;

  sort_engine UUT (
    .clk          (clk),
    .rst          (rst),
    .bank_in      (bank_in),
    .bank_out_vld (bank_out_vld),
    .bank_out     (bank_out),
    .bank_req     (bank_req),
    .bank_rdata   (bank_rdata)
  );

  always #(CLK_NS / 2) clk = ~clk;

  task automatic stop_run();
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic mismatch(input string name, input W_T got, input W_T exp);
    $display("Error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
    stop_run();
  endtask

  task automatic complain(input string what);
    $display("At %0t ns: %s", $time, what);
    stop_run();
  endtask

  // READY bank gets claimed, a claimed bank gets released
  function automatic BANK_STATUS_T expected_status(BANK_STATUS_T in_status);
    return (in_status == READY) ? SORTING : SORTED;
  endfunction

  // Asynchronous read, write on the clock edge
  assign bank_rdata = mem[bank_req.addr];

  always @(posedge clk) begin
    if (fill) begin
      for (int i = 0; i < BANK_N; i++) begin
        mem[i] <= ref_mem[i];
      end
      wr_cnt  <= 0;
      wr_seen <= '0;
    end else if (!rst && bank_req.en && bank_req.wen) begin
      assert (int'(bank_req.addr) < cur_n)
        else complain("store outside the words of the bank");
      assert (!wr_seen[bank_req.addr])
        else complain("bank address stored a second time");
      // Word i of the result is word n-1-i of the original
      assert (bank_req.wdata == ref_mem[cur_n - 1 - int'(bank_req.addr)])
        else mismatch("bank_req.wdata", bank_req.wdata,
                      ref_mem[cur_n - 1 - int'(bank_req.addr)]);
      mem[bank_req.addr]     <= bank_req.wdata;
      wr_seen[bank_req.addr] <= 1'b1;
      wr_cnt                 <= wr_cnt + 1;
    end
  end

  // Engine stays quiet until the first bank is handed over
  assert property (@(posedge clk) disable iff (rst)
    (bank_in.status == IDLE) |-> (!bank_out_vld && !bank_req.en))
    else complain("bank_out_vld or bank_req.en high while the bank is idle");

  // Bank port only touched while the engine owns the bank
  assert property (@(posedge clk) disable iff (rst)
    bank_req.en |-> (bank_in.status == SORTING))
    else complain("bank access while the bank is not SORTING");

  assert property (@(posedge clk) disable iff (rst)
    bank_out_vld |-> (bank_out.status == expected_status(bank_in.status)))
    else mismatch("bank_out.status", W_T'($sampled(bank_out.status)),
                  W_T'(expected_status($sampled(bank_in.status))));

  // Word count passes through unchanged
  assert property (@(posedge clk) disable iff (rst)
    bank_out_vld |-> (int'(bank_out.n) == cur_n))
    else mismatch("bank_out.n", W_T'($sampled(bank_out.n)), W_T'($sampled(cur_n)));

  // Scoreboard mirror of each status pulse
  task automatic wait_pulse();
    do begin
      @(posedge clk);
    end while (!bank_out_vld);
    bank_in <= bank_out;
  endtask

  task automatic verify_bank();
    W_T exp;
    for (int i = 0; i < BANK_N; i++) begin
      // Words past n stay as loaded
      exp = (i < cur_n) ? ref_mem[cur_n - 1 - i] : ref_mem[i];
      assert (mem[i] == exp)
        else mismatch($sformatf("mem[%0d]", i), mem[i], exp);
    end
    assert (wr_cnt == cur_n)
      else mismatch("store count", W_T'(wr_cnt), W_T'(cur_n));
  endtask

  task automatic run_bank(input int n);
    for (int i = 0; i < BANK_N; i++) begin
      ref_mem[i] = $random(seed);
    end
    cur_n = n;
    @(posedge clk);
    fill <= 1'b1;
    @(posedge clk);
    fill    <= 1'b0;
    bank_in <= BANK_STATE_T'{status: READY, n: n[$clog2(BANK_N):0]};
    // SORTING claim, then SORTED release
    wait_pulse();
    wait_pulse();
    verify_bank();
  endtask

  initial begin
    int n;
    rst     = 1'b1;
    bank_in = BANK_STATE_T'{status: IDLE, n: '0};
    fill    = 1'b1;
    cur_n   = 0;
    seed    = 32'ha038;
    // Power-up contents, unique per address
    for (int i = 0; i < BANK_N; i++) begin
      ref_mem[i] = W_T'(i) ^ 32'h5a5a_0000;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    rst  <= 1'b0;
    fill <= 1'b0;
    // Parked at AWAIT with an idle bank
    repeat (20) @(posedge clk);
    // Full bank first, deepest stack use
    run_bank(BANK_N);
    for (int b = 1; b < BANKS; b++) begin
      // Random gap keeps AWAIT stalled for a while
      repeat (3 + ($random(seed) & 7)) @(posedge clk);
      n = 1 + ($random(seed) & (BANK_N - 1));
      run_bank(n);
    end
    $display("ALL TESTS PASSED");
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    complain("watchdog expired before all banks were sorted");
  end

endmodule

/* files.f */
hw/sort_pkg.sv
hw/ucode_rom.sv
hw/ucode_decoder.sv
hw/reg_file.sv
hw/hw_stack.sv
hw/fetch_stage.sv
hw/exec_stage.sv
hw/sort_engine.sv
tests/tb_sort_engine.sv

/* run.sh */
#!/bin/sh
# Build and run the sort engine testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_sort_engine -f files.f -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "SOME TESTS FAILED" "$LOG"; then
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi
exit 0
